// ==== hw/rv_pkg.sv ====
package rv_pkg;

  // Datapath and register file geometry
  localparam int xlen       = 64;
  localparam int instr_w    = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // RV64I major opcodes handled by the core
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg_w  = 7'b0111011;
  localparam logic [6:0] op_imm_w  = 7'b0011011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_system = 7'b1110011;

  typedef logic [xlen-1:0]       double_word;
  typedef logic [instr_w-1:0]    instr_word;
  typedef logic [reg_addr_w-1:0] reg_addr;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b
  } alu_op_e;

  // Where execute takes an operand from
  typedef enum logic [1:0] {
    fwd_none,
    fwd_alu,
    fwd_wb
  } fwd_src_e;

endpackage

// ==== hw/register_file.sv ====
`timescale 1ns/10ps

module register_file (
  input  logic               clk,
  input  logic               arst_n,
  input  rv_pkg::reg_addr    rs1_addr,
  input  rv_pkg::reg_addr    rs2_addr,
  output rv_pkg::double_word rs1_data,
  output rv_pkg::double_word rs2_data,
  input  logic               write_en,
  input  rv_pkg::reg_addr    write_addr,
  input  rv_pkg::double_word write_data
);

  // x0 has no storage
  rv_pkg::double_word regs [1:rv_pkg::num_regs-1];

  // Write-through so a same-cycle write is visible to decode
  function automatic rv_pkg::double_word read_port(input rv_pkg::reg_addr addr);
    if (addr == '0) begin
      return '0;
    end else if (write_en && write_addr == addr) begin
      return write_data;
    end else begin
      return regs[addr];
    end
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

endmodule

// ==== hw/instruction_decode.sv ====
`timescale 1ns/10ps

module instruction_decode (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  input  rv_pkg::instr_word  instr,
  output rv_pkg::reg_addr    rs1_addr,
  output rv_pkg::reg_addr    rs2_addr,
  input  rv_pkg::double_word rs1_data,
  input  rv_pkg::double_word rs2_data,
  input  logic               ex_valid,
  input  logic               ex_write_rd,
  input  rv_pkg::reg_addr    ex_rd,
  input  logic               wb_write_rd,
  input  rv_pkg::reg_addr    wb_rd,
  output logic               dec_valid,
  output rv_pkg::double_word dec_op_1,
  output rv_pkg::double_word dec_op_2,
  output rv_pkg::fwd_src_e   dec_fwd_1,
  output rv_pkg::fwd_src_e   dec_fwd_2,
  output rv_pkg::alu_op_e    dec_alu_op,
  output logic               dec_word_op,
  output rv_pkg::reg_addr    dec_rd,
  output logic               dec_write_rd,
  output logic               dec_final
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  rv_pkg::double_word imm_i;
  rv_pkg::double_word imm_u;
  rv_pkg::double_word op_2_d;
  rv_pkg::alu_op_e    alu_op_d;
  logic               word_op_d;
  logic               uses_rs2_d;
  logic               writes_d;
  logic               final_d;

  // Source indices kept for the forwarding compare in the next cycle
  rv_pkg::reg_addr    src_1_q;
  rv_pkg::reg_addr    src_2_q;
  logic               uses_rs2_q;

  function automatic rv_pkg::alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign imm_i    = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:20]};
  assign imm_u    = {{(rv_pkg::xlen-32){instr[31]}}, instr[31:12], 12'b0};

  always_comb begin
    alu_op_d   = rv_pkg::alu_add;
    op_2_d     = imm_i;
    word_op_d  = 1'b0;
    uses_rs2_d = 1'b0;
    writes_d   = 1'b0;
    final_d    = 1'b0;
    case (opcode)
      rv_pkg::op_reg: begin
        alu_op_d   = funct3_op(funct3, instr[30]);
        op_2_d     = rs2_data;
        uses_rs2_d = 1'b1;
        writes_d   = 1'b1;
      end
      rv_pkg::op_imm: begin
        // Bit 30 of an I immediate only selects SRAI
        alu_op_d = funct3_op(funct3, instr[30] && funct3 == 3'b101);
        writes_d = 1'b1;
      end
      rv_pkg::op_reg_w: begin
        alu_op_d   = funct3_op(funct3, instr[30]);
        op_2_d     = rs2_data;
        word_op_d  = 1'b1;
        uses_rs2_d = 1'b1;
        writes_d   = funct3 inside {3'b000, 3'b001, 3'b101};
      end
      rv_pkg::op_imm_w: begin
        alu_op_d  = funct3_op(funct3, instr[30] && funct3 == 3'b101);
        word_op_d = 1'b1;
        writes_d  = funct3 inside {3'b000, 3'b001, 3'b101};
      end
      rv_pkg::op_lui: begin
        alu_op_d = rv_pkg::alu_pass_b;
        op_2_d   = imm_u;
        writes_d = 1'b1;
      end
      rv_pkg::op_system: begin
        final_d = funct3 == 3'b000 && instr[31:20] == 12'h000;
      end
      default: begin
        writes_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid    <= 1'b0;
      dec_op_1     <= '0;
      dec_op_2     <= '0;
      dec_alu_op   <= rv_pkg::alu_add;
      dec_word_op  <= 1'b0;
      dec_rd       <= '0;
      dec_write_rd <= 1'b0;
      dec_final    <= 1'b0;
      src_1_q      <= '0;
      src_2_q      <= '0;
      uses_rs2_q   <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
      if (instr_valid) begin
        dec_op_1     <= rs1_data;
        dec_op_2     <= op_2_d;
        dec_alu_op   <= alu_op_d;
        dec_word_op  <= word_op_d;
        dec_rd       <= instr[11:7];
        dec_write_rd <= writes_d && instr[11:7] != '0;
        dec_final    <= final_d;
        src_1_q      <= rs1_addr;
        src_2_q      <= rs2_addr;
        uses_rs2_q   <= uses_rs2_d;
      end
    end
  end

  // Newest producer wins
  function automatic rv_pkg::fwd_src_e pick_src(input rv_pkg::reg_addr src, input logic used);
    if (!used || src == '0) begin
      return rv_pkg::fwd_none;
    end else if (ex_valid && ex_write_rd && ex_rd == src) begin
      return rv_pkg::fwd_alu;
    end else if (wb_write_rd && wb_rd == src) begin
      return rv_pkg::fwd_wb;
    end else begin
      return rv_pkg::fwd_none;
    end
  endfunction

  always_comb begin
    dec_fwd_1 = pick_src(src_1_q, 1'b1);
    dec_fwd_2 = pick_src(src_2_q, uses_rs2_q);
  end

endmodule

// ==== hw/execute.sv ====
`timescale 1ns/10ps

module execute (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               dec_valid,
  input  rv_pkg::double_word dec_op_1,
  input  rv_pkg::double_word dec_op_2,
  input  rv_pkg::fwd_src_e   dec_fwd_1,
  input  rv_pkg::fwd_src_e   dec_fwd_2,
  input  rv_pkg::alu_op_e    dec_alu_op,
  input  logic               dec_word_op,
  input  rv_pkg::reg_addr    dec_rd,
  input  logic               dec_write_rd,
  input  logic               dec_final,
  input  rv_pkg::double_word wb_value,
  output logic               ex_valid,
  output rv_pkg::reg_addr    ex_rd,
  output logic               ex_write_rd,
  output logic               ex_final,
  output rv_pkg::double_word ex_result
);

  rv_pkg::double_word op_a;
  rv_pkg::double_word op_b;
  rv_pkg::double_word raw;
  rv_pkg::double_word result_d;
  logic [5:0]         shamt;

  function automatic rv_pkg::double_word operand(input rv_pkg::fwd_src_e src,
                                                 input rv_pkg::double_word decoded);
    case (src)
      rv_pkg::fwd_alu: return ex_result;
      rv_pkg::fwd_wb:  return wb_value;
      default:         return decoded;
    endcase
  endfunction

  always_comb begin
    op_a = operand(dec_fwd_1, dec_op_1);
    op_b = operand(dec_fwd_2, dec_op_2);
  end

  // Word shifts only look at 5 bits
  assign shamt = dec_word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

  always_comb begin
    case (dec_alu_op)
      rv_pkg::alu_add:  raw = op_a + op_b;
      rv_pkg::alu_sub:  raw = op_a - op_b;
      rv_pkg::alu_and:  raw = op_a & op_b;
      rv_pkg::alu_or:   raw = op_a | op_b;
      rv_pkg::alu_xor:  raw = op_a ^ op_b;
      rv_pkg::alu_sll:  raw = op_a << shamt;
      rv_pkg::alu_srl: begin
        if (dec_word_op) raw = {32'b0, op_a[31:0]} >> shamt;
        else raw = op_a >> shamt;
      end
      rv_pkg::alu_sra: begin
        if (dec_word_op) raw = $signed({{32{op_a[31]}}, op_a[31:0]}) >>> shamt;
        else raw = $signed(op_a) >>> shamt;
      end
      rv_pkg::alu_slt:  raw = {{(rv_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu: raw = {{(rv_pkg::xlen-1){1'b0}}, op_a < op_b};
      default:          raw = op_b;
    endcase
    result_d = dec_word_op ? {{32{raw[31]}}, raw[31:0]} : raw;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid    <= 1'b0;
      ex_rd       <= '0;
      ex_write_rd <= 1'b0;
      ex_final    <= 1'b0;
      ex_result   <= '0;
    end else begin
      ex_valid <= dec_valid;
      if (dec_valid) begin
        ex_rd       <= dec_rd;
        ex_write_rd <= dec_write_rd;
        ex_final    <= dec_final;
        ex_result   <= result_d;
      end
    end
  end

endmodule

// ==== hw/writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               ex_valid,
  input  rv_pkg::reg_addr    ex_rd,
  input  logic               ex_write_rd,
  input  logic               ex_final,
  input  rv_pkg::double_word ex_result,
  output logic               wb_valid,
  output rv_pkg::reg_addr    wb_rd,
  output logic               wb_write_rd,
  output rv_pkg::double_word wb_value,
  output logic               reg_write_en,
  output logic               done
);

  // Nothing retires once the program has ended
  assign reg_write_en = ex_valid && ex_write_rd && !done;

  // Every strobe is a register write
  assign wb_write_rd = wb_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
      wb_rd    <= '0;
      wb_value <= '0;
      done     <= 1'b0;
    end else begin
      wb_valid <= reg_write_en;
      if (reg_write_en) begin
        wb_rd    <= ex_rd;
        wb_value <= ex_result;
      end
      if (ex_valid && ex_final) begin
        done <= 1'b1;
      end
    end
  end

endmodule

// ==== hw/core_top.sv ====
`timescale 1ns/10ps

module core_top (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  input  rv_pkg::instr_word  instr,
  output logic               wb_valid,
  output rv_pkg::reg_addr    wb_rd,
  output rv_pkg::double_word wb_value,
  output logic               done
);

  rv_pkg::reg_addr    rs1_addr;
  rv_pkg::reg_addr    rs2_addr;
  rv_pkg::double_word rs1_data;
  rv_pkg::double_word rs2_data;

  logic               dec_valid;
  rv_pkg::double_word dec_op_1;
  rv_pkg::double_word dec_op_2;
  rv_pkg::fwd_src_e   dec_fwd_1;
  rv_pkg::fwd_src_e   dec_fwd_2;
  rv_pkg::alu_op_e    dec_alu_op;
  logic               dec_word_op;
  rv_pkg::reg_addr    dec_rd;
  logic               dec_write_rd;
  logic               dec_final;

  logic               ex_valid;
  rv_pkg::reg_addr    ex_rd;
  logic               ex_write_rd;
  logic               ex_final;
  rv_pkg::double_word ex_result;

  logic               wb_write_rd;
  logic               reg_write_en;

  register_file regs (
    .clk, .arst_n,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .write_en  (reg_write_en),
    .write_addr(ex_rd),
    .write_data(ex_result)
  );

  instruction_decode decode (
    .clk, .arst_n, .instr_valid, .instr,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .ex_valid, .ex_write_rd, .ex_rd, .wb_write_rd, .wb_rd,
    .dec_valid, .dec_op_1, .dec_op_2, .dec_fwd_1, .dec_fwd_2,
    .dec_alu_op, .dec_word_op, .dec_rd, .dec_write_rd, .dec_final
  );

  execute alu_stage (
    .clk, .arst_n,
    .dec_valid, .dec_op_1, .dec_op_2, .dec_fwd_1, .dec_fwd_2,
    .dec_alu_op, .dec_word_op, .dec_rd, .dec_write_rd, .dec_final,
    .wb_value,
    .ex_valid, .ex_rd, .ex_write_rd, .ex_final, .ex_result
  );

  writeback_stage writeback (
    .clk, .arst_n,
    .ex_valid, .ex_rd, .ex_write_rd, .ex_final, .ex_result,
    .wb_valid, .wb_rd, .wb_write_rd, .wb_value, .reg_write_en, .done
  );

endmodule

// ==== testbench/core_assertions.sv ====
`timescale 1ns/10ps

module core_assertions (
  input logic            clk,
  input logic            arst_n,
  input logic            instr_valid,
  input logic            wb_valid,
  input rv_pkg::reg_addr wb_rd,
  input logic            done
);

  // Fixed three-cycle pipeline
  strobe_latency: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid |-> $past(instr_valid, 3))
    else $error("wb_valid without an instruction three cycles before");

  done_sticky: assert property (@(posedge clk) disable iff (!arst_n) !$fell(done))
    else $error("done fell before reset");

  no_x0_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid |-> wb_rd != '0)
    else $error("writeback strobe for x0");

  quiet_after_done: assert property (@(posedge clk) disable iff (!arst_n)
    $past(done) |-> !wb_valid)
    else $error("writeback strobe after the program ended");

endmodule

bind core_top core_assertions checks (
  .clk, .arst_n, .instr_valid, .wb_valid, .wb_rd, .done
);

// ==== testbench/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;

  logic               clk;
  logic               arst_n;
  logic               instr_valid;
  rv_pkg::instr_word  instr;
  logic               wb_valid;
  rv_pkg::reg_addr    wb_rd;
  rv_pkg::double_word wb_value;
  logic               done;

  integer seed = 32'ha9fa_ae61;
  int     cycles = 0;
  int     cycle_limit = 0;
  int     ecall_idx = -1;
  int     done_cycle = -1;

  // Program table and the expected results from the reference model
  rv_pkg::instr_word prog [64];
  int                gap [64];
  logic [4:0]        exp_rd [64];
  logic [63:0]       exp_val [64];
  logic              silent [64];
  int                num_entries = 0;

  // Writebacks still to come with the oldest first
  logic [63:0] pend_rd [$];
  logic [63:0] pend_val [$];
  logic [63:0] pend_cycle [$];

  core_top UUT (
    .clk, .arst_n, .instr_valid, .instr,
    .wb_valid, .wb_rd, .wb_value, .done
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, expected));
    end
  endtask

  function automatic rv_pkg::instr_word r_op(input logic [6:0] opc, input int f7, input int f3,
                                             input int rd, input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_pkg::instr_word i_op(input logic [6:0] opc, input int f3, input int rd,
                                             input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_pkg::instr_word lui(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], rv_pkg::op_lui};
  endfunction

  function automatic int draw_gap();
    return $unsigned($random(seed)) % 4;
  endfunction

  task automatic add_entry(input rv_pkg::instr_word word, input int idle);
    prog[num_entries] = word;
    gap[num_entries]  = idle;
    num_entries++;
  endtask

  // RV64I semantics of the 64-bit forms
  function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
                                        input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = {63'd0, $signed(a) < $signed(b)};
      3'd3: r = {63'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[5:0];
        else r = a >> b[5:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Word forms work on the low half and sign-extend bit 31
  function automatic logic [63:0] alu32(input logic [2:0] f3, input logic alt,
                                        input logic [63:0] a, input logic [63:0] b);
    logic [31:0] lo;
    case (f3)
      3'd0: lo = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      3'd1: lo = a[31:0] << b[4:0];
      default: begin
        if (alt) lo = $signed(a[31:0]) >>> b[4:0];
        else lo = a[31:0] >> b[4:0];
      end
    endcase
    return {{32{lo[31]}}, lo};
  endfunction

  task automatic build_program();
    // Immediates from x0
    add_entry(i_op(rv_pkg::op_imm, 0, 1, 0, -5), draw_gap());
    add_entry(i_op(rv_pkg::op_imm, 4, 2, 0, 'h5a5), draw_gap());
    add_entry(i_op(rv_pkg::op_imm, 4, 3, 0, 'h8f0), draw_gap());
    add_entry(i_op(rv_pkg::op_imm, 6, 4, 0, 'h7ff), draw_gap());
    add_entry(i_op(rv_pkg::op_imm, 3, 5, 0, 1), draw_gap());
    add_entry(lui(6, 'h80001), draw_gap());
    add_entry(lui(7, 'h12345), draw_gap());
    // Back to back dependencies at distances 1, 2 and 3
    add_entry(r_op(rv_pkg::op_reg, 0, 0, 8, 6, 7), 0);
    add_entry(r_op(rv_pkg::op_reg, 'h20, 0, 9, 8, 1), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 4, 10, 8, 9), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 6, 11, 2, 3), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 7, 12, 9, 11), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 2, 13, 1, 2), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 3, 14, 1, 2), 0);
    add_entry(i_op(rv_pkg::op_imm, 0, 16, 0, 7), 0);
    add_entry(i_op(rv_pkg::op_imm, 0, 16, 16, 9), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 0, 16, 16, 16), 0);
    add_entry(r_op(rv_pkg::op_reg, 'h20, 0, 17, 0, 16), 0);
    add_entry(i_op(rv_pkg::op_imm, 0, 19, 0, 'h65), 0);
    add_entry(i_op(rv_pkg::op_imm, 0, 20, 0, 1), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 1, 21, 7, 19), 0);
    add_entry(r_op(rv_pkg::op_reg, 'h20, 5, 22, 1, 20), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 5, 23, 6, 19), 0);
    // Word overflow and shift amount widths
    add_entry(lui(24, 'h7ffff), draw_gap());
    add_entry(i_op(rv_pkg::op_imm_w, 0, 25, 24, 'h7ff), draw_gap());
    add_entry(r_op(rv_pkg::op_reg_w, 0, 0, 26, 25, 25), draw_gap());
    add_entry(lui(28, 'h80000), draw_gap());
    add_entry(r_op(rv_pkg::op_reg_w, 'h20, 0, 29, 28, 20), draw_gap());
    add_entry(i_op(rv_pkg::op_imm_w, 0, 30, 29, 1), draw_gap());
    add_entry(i_op(rv_pkg::op_imm, 1, 31, 20, 40), draw_gap());
    add_entry(i_op(rv_pkg::op_imm, 5, 3, 1, 'h400 + 63), draw_gap());
    add_entry(i_op(rv_pkg::op_imm_w, 1, 5, 20, 31), draw_gap());
    add_entry(r_op(rv_pkg::op_reg_w, 'h20, 5, 10, 28, 19), draw_gap());
    add_entry(r_op(rv_pkg::op_reg_w, 0, 5, 11, 28, 19), draw_gap());
    add_entry(i_op(rv_pkg::op_imm, 5, 12, 28, 60), draw_gap());
    // Writes to x0 and later reads of it
    add_entry(i_op(rv_pkg::op_imm, 0, 0, 0, 123), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 0, 0, 1, 2), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 0, 14, 0, 0), 0);
    add_entry(r_op(rv_pkg::op_reg, 0, 6, 15, 0, 1), 0);
    // ECALL and a tail that must stay silent
    add_entry(i_op(rv_pkg::op_system, 0, 0, 0, 0), draw_gap());
    add_entry(i_op(rv_pkg::op_imm, 0, 1, 0, 1), draw_gap());
    add_entry(lui(2, 'habcde), draw_gap());
    add_entry(r_op(rv_pkg::op_reg, 0, 0, 9, 1, 2), draw_gap());
  endtask

  task automatic predict_all();
    logic [63:0]       mregs [32];
    logic [63:0]       a;
    logic [63:0]       b;
    logic [63:0]       imm;
    logic [63:0]       r;
    logic [2:0]        f3;
    logic [4:0]        rd;
    logic              writes;
    logic              ended;
    rv_pkg::instr_word w;
    ended = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    for (int n = 0; n < num_entries; n++) begin
      w      = prog[n];
      f3     = w[14:12];
      rd     = w[11:7];
      a      = mregs[w[19:15]];
      b      = mregs[w[24:20]];
      imm    = {{52{w[31]}}, w[31:20]};
      r      = '0;
      writes = 1'b1;
      case (w[6:0])
        rv_pkg::op_reg:   r = alu64(f3, w[30], a, b);
        rv_pkg::op_imm:   r = alu64(f3, w[30] && f3 == 3'd5, a, imm);
        rv_pkg::op_reg_w: begin
          r      = alu32(f3, w[30], a, b);
          writes = f3 inside {3'd0, 3'd1, 3'd5};
        end
        rv_pkg::op_imm_w: begin
          r      = alu32(f3, w[30] && f3 == 3'd5, a, imm);
          writes = f3 inside {3'd0, 3'd1, 3'd5};
        end
        rv_pkg::op_lui:   r = {{32{w[31]}}, w[31:12], 12'h000};
        default: begin
          writes = 1'b0;
          if (w == 32'h0000_0073 && !ended) begin
            ended     = 1'b1;
            ecall_idx = n;
          end
        end
      endcase
      silent[n]  = ended || !writes || rd == 5'd0;
      exp_rd[n]  = rd;
      exp_val[n] = r;
      if (!silent[n]) mregs[rd] = r;
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      fail_run($sformatf("Timeout: the run did not end within %0d cycles", cycle_limit));
    end
  end

  always @(negedge clk) begin
    // done rises three cycles after the ECALL is taken
    if (arst_n) begin
      check_value("done", {63'd0, done},
                  {63'd0, (done_cycle >= 0 && cycles >= done_cycle)});
    end
    if (arst_n && wb_valid) begin
      if (pend_rd.size() == 0) begin
        fail_run("A writeback strobe arrived with no instruction pending");
      end else begin
        check_value("wb_rd", {59'd0, wb_rd}, pend_rd.pop_front());
        check_value("wb_value", wb_value, pend_val.pop_front());
        check_value("strobe latency", 64'(cycles) - pend_cycle.pop_front(), 64'd3);
      end
    end
  end

  initial begin
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    build_program();
    predict_all();
    cycle_limit = 4 * num_entries + 20;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    for (int n = 0; n < num_entries; n++) begin
      instr_valid = 1'b1;
      instr       = prog[n];
      if (!silent[n]) begin
        pend_rd.push_back({59'd0, exp_rd[n]});
        pend_val.push_back(exp_val[n]);
        pend_cycle.push_back(64'(cycles));
      end
      if (n == ecall_idx) begin
        done_cycle = cycles + 3;
      end
      @(negedge clk);
      instr_valid = 1'b0;
      repeat (gap[n]) @(negedge clk);
    end
    while (!done) @(negedge clk);
    // Let the tail behind the ECALL drain
    repeat (4) @(negedge clk);
    if (pend_rd.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_run($sformatf("%0d expected writebacks never arrived", pend_rd.size()));
    end
  end

endmodule

// ==== sources.f ====
hw/rv_pkg.sv
hw/register_file.sv
hw/instruction_decode.sv
hw/execute.sv
hw/writeback_stage.sv
hw/core_top.sv
testbench/core_assertions.sv
testbench/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --assert --top-module core_tb -f sources.f -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -q "^sim passed$" &&
echo "RESULT: PASS" ||
{
  echo "RESULT: FAIL"
  exit 1
}
